// ==== project.f ====
rtl/decoder_pkg.sv
rtl/trellis_pkg.sv
rtl/block_sequencer.sv
rtl/trellis_store.sv
rtl/beta_recursion.sv
rtl/llr_max_tree.sv
rtl/extrinsic_scale.sv
rtl/beta_llr_top.sv
test/clock_gen.sv
test/tb_beta_llr.sv

// ==== rtl/beta_llr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module beta_llr_top (
	input  wire                    clk,
	input  wire                    rst,
	input  decoder_pkg::addr_t     blklen_i,
	input  wire                    valid_blklen_i,
	input  decoder_pkg::step_in_t  step_i,
	input  wire                    valid_step_i,
	output decoder_pkg::metric_t   llr_o,
	output decoder_pkg::metric_t   extrinsic_o,
	output logic                   valid_o,
	output logic                   busy_o
);

	logic                    wr_en;
	logic                    rd_en;
	logic                    rd_first;
	decoder_pkg::addr_t      addr;
	decoder_pkg::step_rd_t   rec;
	logic                    rec_valid;
	trellis_pkg::llr_op_t    op;
	logic                    op_valid;
	decoder_pkg::soft_pair_t pair;
	logic                    pair_valid;

	block_sequencer u_block_sequencer (
		.clk            (clk),
		.rst            (rst),
		.blklen_i       (blklen_i),
		.valid_blklen_i (valid_blklen_i),
		.valid_step_i   (valid_step_i),
		.wr_en_o        (wr_en),
		.rd_en_o        (rd_en),
		.first_o        (rd_first),
		.addr_o         (addr),
		.busy_o         (busy_o)
	);

	trellis_store u_trellis_store (
		.clk     (clk),
		.wr_en_i (wr_en),
		.rd_en_i (rd_en),
		.first_i (rd_first),
		.addr_i  (addr),
		.step_i  (step_i),
		.rec_o   (rec),
		.valid_o (rec_valid)
	);

	beta_recursion u_beta_recursion (
		.clk     (clk),
		.rst     (rst),
		.rec_i   (rec),
		.valid_i (rec_valid),
		.op_o    (op),
		.valid_o (op_valid)
	);

	llr_max_tree u_llr_max_tree (
		.clk     (clk),
		.rst     (rst),
		.op_i    (op),
		.valid_i (op_valid),
		.pair_o  (pair),
		.valid_o (pair_valid)
	);

	extrinsic_scale u_extrinsic_scale (
		.clk         (clk),
		.rst         (rst),
		.pair_i      (pair),
		.valid_i     (pair_valid),
		.llr_o       (llr_o),
		.extrinsic_o (extrinsic_o),
		.valid_o     (valid_o)
	);

endmodule

`default_nettype wire

// ==== rtl/beta_recursion.sv ====
`timescale 1ns/1ps
`default_nettype none

module beta_recursion (
	input  wire                    clk,
	input  wire                    rst,
	input  decoder_pkg::step_rd_t  rec_i,
	input  wire                    valid_i,
	output trellis_pkg::llr_op_t   op_o,
	output logic                   valid_o
);

	trellis_pkg::beta_vec_t beta_q;
	trellis_pkg::beta_vec_t beta_next;
	trellis_pkg::beta_t     beta_cur [trellis_pkg::num_states];

	always_comb begin
		decoder_pkg::metric_t b1;
		decoder_pkg::metric_t b2;
		trellis_pkg::beta_t   br;
		trellis_pkg::beta_t   sum_p;
		trellis_pkg::beta_t   sum_m;
		trellis_pkg::beta_t   raw [trellis_pkg::num_states];

		b1 = rec_i.step.branch1;
		b2 = rec_i.step.branch2;

		// Beta of step k+1, or the start vector on the last step
		for (int s = 0; s < trellis_pkg::num_states; s++) begin
			if (!rec_i.first)
				beta_cur[s] = beta_q[s];
			else if (s == 0)
				beta_cur[s] = trellis_pkg::beta_init_zero;
			else
				beta_cur[s] = trellis_pkg::beta_init_other;
		end

		for (int s = 0; s < trellis_pkg::num_states; s++) begin
			br     = trellis_pkg::branch_sel[s] ? trellis_pkg::beta_t'(b2) :
			                                       trellis_pkg::beta_t'(b1);
			sum_p  = beta_cur[trellis_pkg::beta_plus_src[s]] + br;
			sum_m  = beta_cur[trellis_pkg::beta_minus_src[s]] - br;
			raw[s] = (sum_p > sum_m) ? sum_p : sum_m;
		end

		// Normalize so state 0 stays at zero
		for (int s = 0; s < trellis_pkg::num_states; s++)
			beta_next[s] = raw[s] - raw[0];
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			beta_q       <= beta_next;
			op_o.alpha   <= rec_i.step.alpha;
			op_o.branch1 <= rec_i.step.branch1;
			op_o.branch2 <= rec_i.step.branch2;
			op_o.sys     <= rec_i.step.sys;
			op_o.apriori <= rec_i.step.apriori;
			for (int s = 0; s < trellis_pkg::num_states; s++)
				op_o.beta[s] <= beta_cur[s];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

endmodule

`default_nettype wire

// ==== rtl/block_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_sequencer (
	input  wire                 clk,
	input  wire                 rst,
	input  decoder_pkg::addr_t  blklen_i,
	input  wire                 valid_blklen_i,
	input  wire                 valid_step_i,
	output logic                wr_en_o,
	output logic                rd_en_o,
	output logic                first_o,
	output decoder_pkg::addr_t  addr_o,
	output logic                busy_o
);

	decoder_pkg::seq_state_e state_q;
	decoder_pkg::addr_t      len_q;
	decoder_pkg::addr_t      cnt_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= decoder_pkg::IDLE;
			len_q   <= '0;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				decoder_pkg::IDLE: begin
					if (valid_blklen_i) begin
						state_q <= decoder_pkg::LOAD;
						len_q   <= blklen_i;
						cnt_q   <= '0;
					end
				end
				decoder_pkg::LOAD: begin
					// Last write leaves the counter on the top address
					if (valid_step_i) begin
						if (cnt_q == len_q - 1'b1)
							state_q <= decoder_pkg::BACKWARD;
						else
							cnt_q <= cnt_q + 1'b1;
					end
				end
				decoder_pkg::BACKWARD: begin
					if (cnt_q == '0)
						state_q <= decoder_pkg::IDLE;
					else
						cnt_q <= cnt_q - 1'b1;
				end
				default: state_q <= decoder_pkg::IDLE;
			endcase
		end
	end

	assign wr_en_o = (state_q == decoder_pkg::LOAD) && valid_step_i;
	assign rd_en_o = (state_q == decoder_pkg::BACKWARD);
	assign first_o = rd_en_o && (cnt_q == len_q - 1'b1);
	assign addr_o  = cnt_q;
	assign busy_o  = (state_q != decoder_pkg::IDLE);

endmodule

`default_nettype wire

// ==== rtl/decoder_pkg.sv ====
`default_nettype none

package decoder_pkg;

	//////////////////////////////////////////////////
	// Word and block sizes
	//////////////////////////////////////////////////

	localparam int word_w     = 16;
	localparam int max_blklen = 6144;
	localparam int addr_w     = $clog2(max_blklen);

	typedef logic signed [word_w-1:0] metric_t;
	typedef logic [addr_w-1:0] addr_t;

	//////////////////////////////////////////////////
	// Stream records
	//////////////////////////////////////////////////

	// One trellis step as loaded
	typedef struct packed {
		metric_t       branch1;
		metric_t       branch2;
		metric_t [7:0] alpha;
		metric_t       sys;
		metric_t       apriori;
	} step_in_t;

	// Step read back during the backward pass
	typedef struct packed {
		logic     first;
		step_in_t step;
	} step_rd_t;

	typedef struct packed {
		metric_t llr;
		metric_t sys;
		metric_t apriori;
	} soft_pair_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		BACKWARD
	} seq_state_e;

endpackage

`default_nettype wire

// ==== rtl/extrinsic_scale.sv ====
`timescale 1ns/1ps
`default_nettype none

module extrinsic_scale (
	input  wire                      clk,
	input  wire                      rst,
	input  decoder_pkg::soft_pair_t  pair_i,
	input  wire                      valid_i,
	output decoder_pkg::metric_t     llr_o,
	output decoder_pkg::metric_t     extrinsic_o,
	output logic                     valid_o
);

	decoder_pkg::metric_t            d_q;
	decoder_pkg::metric_t            llr_q;
	logic                            valid_q;
	logic [decoder_pkg::word_w-1:0]  mag;
	logic [decoder_pkg::word_w-1:0]  quo;
	decoder_pkg::metric_t            ext;

	always_ff @(posedge clk) begin
		d_q   <= pair_i.llr - pair_i.sys - pair_i.apriori;
		llr_q <= pair_i.llr;
	end

	// Quarter of |d|, rounded up only on remainder 3
	always_comb begin
		mag = d_q[decoder_pkg::word_w-1] ? -d_q : d_q;
		quo = (mag >> 2) + {{(decoder_pkg::word_w-1){1'b0}}, (mag[1:0] == 2'b11)};
		if (d_q[decoder_pkg::word_w-1])
			ext = d_q + decoder_pkg::metric_t'(quo);
		else
			ext = d_q - decoder_pkg::metric_t'(quo);
	end

	always_ff @(posedge clk) begin
		llr_o       <= llr_q;
		extrinsic_o <= ext;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_q <= valid_i;
			valid_o <= valid_q;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/llr_max_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module llr_max_tree (
	input  wire                      clk,
	input  wire                      rst,
	input  trellis_pkg::llr_op_t     op_i,
	input  wire                      valid_i,
	output decoder_pkg::soft_pair_t  pair_o,
	output logic                     valid_o
);

	decoder_pkg::metric_t sum_minus_d [trellis_pkg::num_states];
	decoder_pkg::metric_t sum_plus_d  [trellis_pkg::num_states];
	decoder_pkg::metric_t sum_minus_q [trellis_pkg::num_states];
	decoder_pkg::metric_t sum_plus_q  [trellis_pkg::num_states];
	decoder_pkg::metric_t max_minus_q [4];
	decoder_pkg::metric_t max_plus_q  [4];
	decoder_pkg::metric_t sys_q       [2];
	decoder_pkg::metric_t apriori_q   [2];
	logic [2:0]           valid_q;

	function automatic decoder_pkg::metric_t max2(
		input decoder_pkg::metric_t a,
		input decoder_pkg::metric_t b
	);
		return (a > b) ? a : b;
	endfunction

	//////////////////////////////////////////////////
	// Path sums, beta cut to the word width
	//////////////////////////////////////////////////

	always_comb begin
		decoder_pkg::metric_t br;
		decoder_pkg::metric_t beta_m;
		decoder_pkg::metric_t beta_p;

		for (int s = 0; s < trellis_pkg::num_states; s++) begin
			br     = trellis_pkg::branch_sel[s] ? op_i.branch2 : op_i.branch1;
			beta_m = op_i.beta[trellis_pkg::llr1_beta_map[s]][decoder_pkg::word_w-1:0];
			beta_p = op_i.beta[trellis_pkg::llr2_beta_map[s]][decoder_pkg::word_w-1:0];
			sum_minus_d[s] = op_i.alpha[s] - br + beta_m;
			sum_plus_d[s]  = op_i.alpha[s] + br + beta_p;
		end
	end

	always_ff @(posedge clk) begin
		sum_minus_q  <= sum_minus_d;
		sum_plus_q   <= sum_plus_d;
		sys_q[0]     <= op_i.sys;
		apriori_q[0] <= op_i.apriori;
	end

	//////////////////////////////////////////////////
	// Max trees
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			max_minus_q[i] <= max2(sum_minus_q[2*i], sum_minus_q[2*i+1]);
			max_plus_q[i]  <= max2(sum_plus_q[2*i], sum_plus_q[2*i+1]);
		end
		sys_q[1]     <= sys_q[0];
		apriori_q[1] <= apriori_q[0];
	end

	always_ff @(posedge clk) begin
		pair_o.llr <= max2(max2(max_minus_q[0], max_minus_q[1]),
		                   max2(max_minus_q[2], max_minus_q[3])) -
		              max2(max2(max_plus_q[0], max_plus_q[1]),
		                   max2(max_plus_q[2], max_plus_q[3]));
		pair_o.sys     <= sys_q[1];
		pair_o.apriori <= apriori_q[1];
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= '0;
		else
			valid_q <= {valid_q[1:0], valid_i};
	end

	assign valid_o = valid_q[2];

endmodule

`default_nettype wire

// ==== rtl/trellis_pkg.sv ====
`default_nettype none

package trellis_pkg;

	localparam int num_states = 8;
	localparam int beta_w     = 19;

	typedef logic signed [beta_w-1:0] beta_t;
	typedef beta_t [num_states-1:0] beta_vec_t;

	// Start of the backward pass, state 0 favoured
	localparam beta_t beta_init_zero  = 0;
	localparam beta_t beta_init_other = -128;

	//////////////////////////////////////////////////
	// State connections
	//////////////////////////////////////////////////

	// Bit set means the state uses branch2
	localparam logic [num_states-1:0] branch_sel = 8'b0011_1100;

	localparam int unsigned beta_plus_src [num_states] = '{0, 4, 5, 1, 2, 6, 7, 3};
	localparam int unsigned beta_minus_src [num_states] = '{4, 0, 1, 5, 6, 2, 3, 7};

	// Beta partner of each alpha state in the LLR paths
	localparam int unsigned llr1_beta_map [num_states] = '{4, 0, 1, 5, 6, 2, 3, 7};
	localparam int unsigned llr2_beta_map [num_states] = '{0, 4, 5, 1, 2, 6, 7, 3};

	typedef struct packed {
		decoder_pkg::metric_t [num_states-1:0] alpha;
		decoder_pkg::metric_t                  branch1;
		decoder_pkg::metric_t                  branch2;
		beta_vec_t                             beta;
		decoder_pkg::metric_t                  sys;
		decoder_pkg::metric_t                  apriori;
	} llr_op_t;

endpackage

`default_nettype wire

// ==== rtl/trellis_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module trellis_store (
	input  wire                    clk,
	input  wire                    wr_en_i,
	input  wire                    rd_en_i,
	input  wire                    first_i,
	input  decoder_pkg::addr_t     addr_i,
	input  decoder_pkg::step_in_t  step_i,
	output decoder_pkg::step_rd_t  rec_o,
	output logic                   valid_o
);

	// One full step record per address
	decoder_pkg::step_in_t mem [decoder_pkg::max_blklen];

	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[addr_i] <= step_i;
	end

	always_ff @(posedge clk) begin
		if (rd_en_i)
			rec_o.step <= mem[addr_i];
	end

	// Strobes follow the read data
	always_ff @(posedge clk) begin
		valid_o     <= rd_en_i;
		rec_o.first <= first_i;
	end

endmodule

`default_nettype wire

// ==== test/beta_llr_patterns.txt ====
// Per block: length, then steps 0..n-1 as branch1 branch2 alpha0..alpha7 sys apriori,
// then expected llr extrinsic pairs in output order (last step first). 16-bit hex.
// Block A
0006
FFF7 0007 0000 0000 0000 0014 0000 0000 FFFC 0000 FFF6 0005
000C 0001 0005 0000 0000 0000 0000 FFFD 0000 0000 0006 0000
FFFD FFFB 0000 0000 0000 0000 0000 0000 0000 0000 0001 FFFF
0006 0002 0000 0000 0000 0000 0000 0000 0000 0000 FFFE FFFE
FFFC 0008 0000 0000 0000 0000 0000 0000 0000 0000 FFFB 0002
000A FFFA 0000 0000 0000 0000 0000 0000 0000 0000 0003 0004
FFEC FFEC
0008 0008
FFFC 0000
0006 0005
FFF8 FFF5
FFF3 FFFA
// Block B
0004
0001 FFFF 0000 0000 0000 0000 0000 0000 0000 0000 FFFF FFFC
0004 FFFE 0000 0000 0000 0000 0000 0000 0000 0000 0002 0002
FFF9 0003 0000 0000 000A 0000 0000 0000 0000 0000 FFF9 0000
0002 0009 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
FFFC FFFD
0008 000B
0004 0000
0002 0005
// Block C, same data as A
0006
FFF7 0007 0000 0000 0000 0014 0000 0000 FFFC 0000 FFF6 0005
000C 0001 0005 0000 0000 0000 0000 FFFD 0000 0000 0006 0000
FFFD FFFB 0000 0000 0000 0000 0000 0000 0000 0000 0001 FFFF
0006 0002 0000 0000 0000 0000 0000 0000 0000 0000 FFFE FFFE
FFFC 0008 0000 0000 0000 0000 0000 0000 0000 0000 FFFB 0002
000A FFFA 0000 0000 0000 0000 0000 0000 0000 0000 0003 0004
FFEC FFEC
0008 0008
FFFC 0000
0006 0005
FFF8 FFF5
FFF3 FFFA

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk_o
);

	localparam time half_period = 4ns;

	initial begin
		clk_o = 1'b0;
		forever #(half_period) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

// ==== test/tb_beta_llr.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_beta_llr;

	localparam int num_blocks = 3;
	localparam int max_steps  = 32;

	logic                    clk;
	logic                    rst;
	decoder_pkg::addr_t      blklen_i;
	logic                    valid_blklen_i;
	decoder_pkg::step_in_t   step_i;
	logic                    valid_step_i;
	decoder_pkg::metric_t    llr_o;
	decoder_pkg::metric_t    extrinsic_o;
	logic                    valid_o;
	logic                    busy_o;

	logic [15:0]             pat [0:255];
	decoder_pkg::step_in_t   step_mem [0:max_steps-1];
	logic [15:0]             exp_llr [0:max_steps-1];
	logic [15:0]             exp_ext [0:max_steps-1];
	int                      blk_len [num_blocks];
	int                      step_base [num_blocks];
	string                   blk_name [num_blocks] = '{"A", "B", "C"};
	int                      total_steps;
	int                      limit_cycles;
	int                      out_blk;
	int                      out_in_blk;
	integer                  seed;

	clock_gen u_clock_gen (
		.clk_o (clk)
	);

	beta_llr_top u_beta_llr_top (
		.clk            (clk),
		.rst            (rst),
		.blklen_i       (blklen_i),
		.valid_blklen_i (valid_blklen_i),
		.step_i         (step_i),
		.valid_step_i   (valid_step_i),
		.llr_o          (llr_o),
		.extrinsic_o    (extrinsic_o),
		.valid_o        (valid_o),
		.busy_o         (busy_o)
	);

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] exp_v,
	                           input logic [15:0] act_v);
		if (act_v !== exp_v) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
			stop_run("Output check failed");
		end
	endtask

	//////////////////////////////////////////////////
	// Pattern file and stimulus
	//////////////////////////////////////////////////

	task automatic parse_patterns();
		int ptr;
		int n;
		ptr = 0;
		n = 0;
		$readmemh("test/beta_llr_patterns.txt", pat);
		if ($isunknown(pat[0]))
			stop_run("Pattern file could not be read");
		for (int b = 0; b < num_blocks; b++) begin
			blk_len[b] = pat[ptr];
			step_base[b] = n;
			ptr++;
			for (int k = 0; k < blk_len[b]; k++) begin
				step_mem[n + k].branch1 = pat[ptr];
				step_mem[n + k].branch2 = pat[ptr + 1];
				for (int j = 0; j < 8; j++)
					step_mem[n + k].alpha[j] = pat[ptr + 2 + j];
				step_mem[n + k].sys     = pat[ptr + 10];
				step_mem[n + k].apriori = pat[ptr + 11];
				ptr += 12;
			end
			// Expected pairs, last step first
			for (int k = 0; k < blk_len[b]; k++) begin
				exp_llr[n + k] = pat[ptr];
				exp_ext[n + k] = pat[ptr + 1];
				ptr += 2;
			end
			n += blk_len[b];
		end
		total_steps = n;
	endtask

	// Called on a falling edge
	task automatic load_block(input int b, input bit use_gaps);
		int gap;
		while (busy_o)
			@(negedge clk);
		blklen_i = decoder_pkg::addr_t'(blk_len[b]);
		valid_blklen_i = 1'b1;
		@(negedge clk);
		valid_blklen_i = 1'b0;
		for (int k = 0; k < blk_len[b]; k++) begin
			gap = use_gaps ? ($unsigned($random(seed)) % 3) : 0;
			repeat (gap) begin
				valid_step_i = 1'b0;
				@(negedge clk);
			end
			step_i = step_mem[step_base[b] + k];
			valid_step_i = 1'b1;
			@(negedge clk);
		end
		valid_step_i = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		int idx;
		if (!rst) begin
			if (valid_o) begin
				if (out_blk >= num_blocks)
					stop_run("valid_o went high after all expected outputs");
				idx = step_base[out_blk] + out_in_blk;
				check_value($sformatf("block %s out %0d llr", blk_name[out_blk], out_in_blk),
				            exp_llr[idx], llr_o);
				check_value($sformatf("block %s out %0d ext", blk_name[out_blk], out_in_blk),
				            exp_ext[idx], extrinsic_o);
				out_in_blk++;
				if (out_in_blk == blk_len[out_blk]) begin
					out_blk++;
					out_in_blk = 0;
				end
			end else if (out_in_blk != 0) begin
				stop_run("valid_o dropped in the middle of a block's outputs");
			end
		end
	end

	// Watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		stop_run($sformatf("Timeout: run did not finish within %0d cycles", limit_cycles));
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		rst            = 1'b1;
		blklen_i       = '0;
		valid_blklen_i = 1'b0;
		step_i         = '0;
		valid_step_i   = 1'b0;
		out_blk        = 0;
		out_in_blk     = 0;
		limit_cycles   = 0;
		seed           = 76585;

		parse_patterns();
		limit_cycles = total_steps * 4 + 100;

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Idle after reset
		repeat (5) begin
			@(negedge clk);
			check_value("idle valid_o", 16'd0, {15'd0, valid_o});
			check_value("idle busy_o", 16'd0, {15'd0, busy_o});
		end

		load_block(0, 1'b0);

		// Block B loads while A still drains
		load_block(1, 1'b1);
		while (busy_o)
			@(negedge clk);
		check_value("busy_o low before block B outputs end", 16'd1,
		            {15'd0, (out_blk <= 1)});

		// Same data as A, so the monitor expects A's results again
		load_block(2, 1'b0);

		while (out_blk < num_blocks)
			@(negedge clk);
		repeat (10) @(negedge clk);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
